//--- source/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath widths
`define DEC_XLEN     64
`define DEC_INST_LEN 32
`define DEC_REG_AW   5

// rv64 major opcodes, inst[6:0]
`define DEC_OPC_LOAD      7'b0000011
`define DEC_OPC_STORE     7'b0100011
`define DEC_OPC_BRANCH    7'b1100011
`define DEC_OPC_JALR      7'b1100111
`define DEC_OPC_JAL       7'b1101111
`define DEC_OPC_OP_IMM    7'b0010011
`define DEC_OPC_OP        7'b0110011
`define DEC_OPC_OP_IMM_32 7'b0011011
`define DEC_OPC_OP_32     7'b0111011
`define DEC_OPC_AUIPC     7'b0010111
`define DEC_OPC_LUI       7'b0110111

`endif

//--- source/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

  typedef logic [`DEC_XLEN-1:0]     xlen_t;
  typedef logic [`DEC_INST_LEN-1:0] inst_t;
  typedef logic [`DEC_REG_AW-1:0]   reg_idx_t;

  // one-hot instruction class, also sent on as the execute op vector
  typedef struct packed {
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic load;
    logic store;
    logic branch;
    logic op_imm;
    logic op_imm_32;
    logic op;
    logic op_32;
  } inst_class_t;

  // immediate format select
  typedef struct packed {
    logic i;
    logic s;
    logic b;
    logic u;
    logic j;
  } imm_fmt_t;

  typedef struct packed {
    // add/sub and logic
    logic add;
    logic sub;
    logic xor_;
    logic or_;
    logic and_;
    // shifts
    logic sll;
    logic srl;
    logic sra;
    logic sllw;
    logic srlw;
    logic sraw;
    // compares and branches
    logic slt;
    logic sltu;
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
    // m extension
    logic mul;
    logic mulh;
    logic mulhsu;
    logic mulhu;
    logic mulw;
    logic div;
    logic divu;
    logic rem;
    logic remu;
    logic divw;
    logic divuw;
    logic remw;
    logic remuw;
  } alu_op_t;

  typedef struct packed {
    logic lb;
    logic lbu;
    logic lh;
    logic lw;
    logic lhu;
    logic lwu;
    logic ld;
    logic sb;
    logic sh;
    logic sw;
    logic sd;
  } mem_op_t;

endpackage

//--- source/opcode_classifier.sv
`include "decode_config.svh"

module opcode_classifier (
  input  decode_pkg::inst_t       inst_i,
  output decode_pkg::inst_class_t class_o,
  output decode_pkg::imm_fmt_t    fmt_o,
  output decode_pkg::reg_idx_t    rs1_o,
  output decode_pkg::reg_idx_t    rs2_o,
  output decode_pkg::reg_idx_t    rd_o,
  output logic                    need_rs1_o,
  output logic                    need_rs2_o,
  output logic                    need_rd_o,
  output logic                    illegal_o
);

  logic [6:0] opcode;
  logic       fmt_r;

  assign opcode = inst_i[6:0];

  // raw register fields, gating happens downstream
  assign rd_o  = inst_i[11:7];
  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];

  // one compare per supported major opcode
  always_comb begin
    class_o           = '0;
    class_o.auipc     = (opcode == `DEC_OPC_AUIPC);
    class_o.lui       = (opcode == `DEC_OPC_LUI);
    class_o.jal       = (opcode == `DEC_OPC_JAL);
    class_o.jalr      = (opcode == `DEC_OPC_JALR);
    class_o.load      = (opcode == `DEC_OPC_LOAD);
    class_o.store     = (opcode == `DEC_OPC_STORE);
    class_o.branch    = (opcode == `DEC_OPC_BRANCH);
    class_o.op_imm    = (opcode == `DEC_OPC_OP_IMM);
    class_o.op_imm_32 = (opcode == `DEC_OPC_OP_IMM_32);
    class_o.op        = (opcode == `DEC_OPC_OP);
    class_o.op_32     = (opcode == `DEC_OPC_OP_32);
  end

  // instruction formats
  assign fmt_r   = class_o.op | class_o.op_32;
  assign fmt_o.i = class_o.load | class_o.op_imm | class_o.op_imm_32 | class_o.jalr;
  assign fmt_o.s = class_o.store;
  assign fmt_o.b = class_o.branch;
  assign fmt_o.u = class_o.auipc | class_o.lui;
  assign fmt_o.j = class_o.jal;

  // which register fields carry a real operand
  assign need_rs1_o = fmt_r | fmt_o.i | fmt_o.s | fmt_o.b;
  assign need_rs2_o = fmt_r | fmt_o.s | fmt_o.b;
  assign need_rd_o  = fmt_r | fmt_o.i | fmt_o.u | fmt_o.j;

  // system, misc-mem and anything unknown land here
  assign illegal_o = ~(|class_o);

endmodule

//--- source/imm_gen.sv
`include "decode_config.svh"

module imm_gen (
  input  decode_pkg::inst_t    inst_i,
  input  decode_pkg::imm_fmt_t fmt_i,
  output decode_pkg::xlen_t    imm_o
);

  logic sign;

  decode_pkg::xlen_t imm_i_type;
  decode_pkg::xlen_t imm_s_type;
  decode_pkg::xlen_t imm_b_type;
  decode_pkg::xlen_t imm_u_type;
  decode_pkg::xlen_t imm_j_type;

  // every format takes its sign from bit 31
  assign sign = inst_i[31];

  assign imm_i_type = {{(`DEC_XLEN-12){sign}}, inst_i[31:20]};
  assign imm_s_type = {{(`DEC_XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
  // branch offset, halfword aligned
  assign imm_b_type = {{(`DEC_XLEN-13){sign}}, inst_i[31], inst_i[7],
                       inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u_type = {{(`DEC_XLEN-32){sign}}, inst_i[31:12], 12'b0};
  // jal offset, halfword aligned
  assign imm_j_type = {{(`DEC_XLEN-21){sign}}, inst_i[31], inst_i[19:12],
                       inst_i[20], inst_i[30:21], 1'b0};

  // format flags are one-hot, R-type falls through to zero
  always_comb begin
    if (fmt_i.i) begin
      imm_o = imm_i_type;
    end else if (fmt_i.s) begin
      imm_o = imm_s_type;
    end else if (fmt_i.b) begin
      imm_o = imm_b_type;
    end else if (fmt_i.u) begin
      imm_o = imm_u_type;
    end else if (fmt_i.j) begin
      imm_o = imm_j_type;
    end else begin
      imm_o = '0;
    end
  end

endmodule

//--- source/op_encoder.sv
module op_encoder (
  input  decode_pkg::inst_t       inst_i,
  input  decode_pkg::inst_class_t class_i,
  output decode_pkg::alu_op_t     alu_op_o,
  output decode_pkg::mem_op_t     mem_op_o
);

  logic [2:0] func3;
  logic [6:0] func7;
  logic [7:0] f3;

  // func7 qualifiers
  logic f7_base;
  logic f7_alt;
  logic f7_mext;
  logic sh_base;
  logic sh_alt;

  // class and func7 combined
  logic op_base;
  logic op_alt;
  logic op_mext;
  logic op32_base;
  logic op32_alt;
  logic op32_mext;
  logic imm32_base;
  logic imm32_alt;

  assign func3 = inst_i[14:12];
  assign func7 = inst_i[31:25];

  // one-hot func3 decode
  always_comb begin
    f3        = '0;
    f3[func3] = 1'b1;
  end

  assign f7_base = (func7 == 7'b0000000);
  assign f7_alt  = (func7 == 7'b0100000);
  assign f7_mext = (func7 == 7'b0000001);
  // rv64 shamt is six bits wide, so func7[0] belongs to it
  assign sh_base = (func7[6:1] == 6'b000000);
  assign sh_alt  = (func7[6:1] == 6'b010000);

  assign op_base    = class_i.op & f7_base;
  assign op_alt     = class_i.op & f7_alt;
  assign op_mext    = class_i.op & f7_mext;
  assign op32_base  = class_i.op_32 & f7_base;
  assign op32_alt   = class_i.op_32 & f7_alt;
  assign op32_mext  = class_i.op_32 & f7_mext;
  assign imm32_base = class_i.op_imm_32 & f7_base;
  assign imm32_alt  = class_i.op_imm_32 & f7_alt;

  always_comb begin
    alu_op_o = '0;
    // address and link arithmetic all go through the adder
    alu_op_o.add = (op_base & f3[0]) | (op32_base & f3[0])
                 | (class_i.op_imm & f3[0]) | (class_i.op_imm_32 & f3[0])
                 | class_i.load | class_i.store | class_i.jal | class_i.jalr
                 | class_i.auipc | class_i.lui;
    alu_op_o.sub  = (op_alt & f3[0]) | (op32_alt & f3[0]);
    alu_op_o.xor_ = (op_base & f3[4]) | (class_i.op_imm & f3[4]);
    alu_op_o.or_  = (op_base & f3[6]) | (class_i.op_imm & f3[6]);
    alu_op_o.and_ = (op_base & f3[7]) | (class_i.op_imm & f3[7]);
    alu_op_o.sll  = (op_base & f3[1]) | (class_i.op_imm & f3[1] & sh_base);
    alu_op_o.srl  = (op_base & f3[5]) | (class_i.op_imm & f3[5] & sh_base);
    alu_op_o.sra  = (op_alt & f3[5]) | (class_i.op_imm & f3[5] & sh_alt);
    alu_op_o.sllw = (op32_base & f3[1]) | (imm32_base & f3[1]);
    alu_op_o.srlw = (op32_base & f3[5]) | (imm32_base & f3[5]);
    alu_op_o.sraw = (op32_alt & f3[5]) | (imm32_alt & f3[5]);
    alu_op_o.slt  = (op_base & f3[2]) | (class_i.op_imm & f3[2]);
    alu_op_o.sltu = (op_base & f3[3]) | (class_i.op_imm & f3[3]);
    // branch compares
    alu_op_o.beq  = class_i.branch & f3[0];
    alu_op_o.bne  = class_i.branch & f3[1];
    alu_op_o.blt  = class_i.branch & f3[4];
    alu_op_o.bge  = class_i.branch & f3[5];
    alu_op_o.bltu = class_i.branch & f3[6];
    alu_op_o.bgeu = class_i.branch & f3[7];
    // multiply and divide
    alu_op_o.mul    = op_mext & f3[0];
    alu_op_o.mulh   = op_mext & f3[1];
    alu_op_o.mulhsu = op_mext & f3[2];
    alu_op_o.mulhu  = op_mext & f3[3];
    alu_op_o.div    = op_mext & f3[4];
    alu_op_o.divu   = op_mext & f3[5];
    alu_op_o.rem    = op_mext & f3[6];
    alu_op_o.remu   = op_mext & f3[7];
    alu_op_o.mulw   = op32_mext & f3[0];
    alu_op_o.divw   = op32_mext & f3[4];
    alu_op_o.divuw  = op32_mext & f3[5];
    alu_op_o.remw   = op32_mext & f3[6];
    alu_op_o.remuw  = op32_mext & f3[7];
  end

  // load and store width from func3
  always_comb begin
    mem_op_o     = '0;
    mem_op_o.lb  = class_i.load & f3[0];
    mem_op_o.lh  = class_i.load & f3[1];
    mem_op_o.lw  = class_i.load & f3[2];
    mem_op_o.ld  = class_i.load & f3[3];
    mem_op_o.lbu = class_i.load & f3[4];
    mem_op_o.lhu = class_i.load & f3[5];
    mem_op_o.lwu = class_i.load & f3[6];
    mem_op_o.sb  = class_i.store & f3[0];
    mem_op_o.sh  = class_i.store & f3[1];
    mem_op_o.sw  = class_i.store & f3[2];
    mem_op_o.sd  = class_i.store & f3[3];
  end

endmodule

//--- source/operand_forward.sv
module operand_forward (
  input  decode_pkg::reg_idx_t rs1_i,
  input  decode_pkg::reg_idx_t rs2_i,
  input  decode_pkg::reg_idx_t rd_i,
  input  logic                 need_rs1_i,
  input  logic                 need_rs2_i,
  input  logic                 need_rd_i,
  input  decode_pkg::xlen_t    rs1_data_i,
  input  decode_pkg::xlen_t    rs2_data_i,
  input  decode_pkg::reg_idx_t ex_rd_addr_i,
  input  decode_pkg::xlen_t    ex_rd_data_i,
  input  decode_pkg::reg_idx_t mem_rd_addr_i,
  input  decode_pkg::xlen_t    mem_rd_data_i,
  input  logic                 prev_is_load_i,
  output decode_pkg::reg_idx_t rs1_idx_o,
  output decode_pkg::reg_idx_t rs2_idx_o,
  output decode_pkg::reg_idx_t rd_idx_o,
  output decode_pkg::xlen_t    rs1_data_o,
  output decode_pkg::xlen_t    rs2_data_o,
  output logic                 load_use_o
);

  logic rs1_nz;
  logic rs2_nz;
  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;

  // unused fields read as x0
  assign rs1_idx_o = need_rs1_i ? rs1_i : '0;
  assign rs2_idx_o = need_rs2_i ? rs2_i : '0;
  assign rd_idx_o  = need_rd_i ? rd_i : '0;

  // x0 is hardwired, never bypass it
  assign rs1_nz = (rs1_idx_o != '0);
  assign rs2_nz = (rs2_idx_o != '0);

  assign rs1_ex_hit  = rs1_nz & (rs1_idx_o == ex_rd_addr_i);
  assign rs2_ex_hit  = rs2_nz & (rs2_idx_o == ex_rd_addr_i);
  assign rs1_mem_hit = rs1_nz & (rs1_idx_o == mem_rd_addr_i);
  assign rs2_mem_hit = rs2_nz & (rs2_idx_o == mem_rd_addr_i);

  // youngest producer wins: ex, then mem, then register file
  assign rs1_data_o = rs1_ex_hit  ? ex_rd_data_i  :
                      rs1_mem_hit ? mem_rd_data_i : rs1_data_i;
  assign rs2_data_o = rs2_ex_hit  ? ex_rd_data_i  :
                      rs2_mem_hit ? mem_rd_data_i : rs2_data_i;

  // load data not ready yet in ex, pipeline must bubble
  assign load_use_o = prev_is_load_i & (rs1_ex_hit | rs2_ex_hit);

endmodule

//--- source/inst_decode.sv
module inst_decode (
  input  decode_pkg::inst_t       inst_i,
  input  decode_pkg::xlen_t       rs1_data_i,
  input  decode_pkg::xlen_t       rs2_data_i,
  input  decode_pkg::reg_idx_t    ex_rd_addr_i,
  input  decode_pkg::xlen_t       ex_rd_data_i,
  input  decode_pkg::reg_idx_t    mem_rd_addr_i,
  input  decode_pkg::xlen_t       mem_rd_data_i,
  input  logic                    prev_is_load_i,
  output decode_pkg::reg_idx_t    rs1_idx_o,
  output decode_pkg::reg_idx_t    rs2_idx_o,
  output decode_pkg::reg_idx_t    rd_idx_o,
  output decode_pkg::xlen_t       rs1_data_o,
  output decode_pkg::xlen_t       rs2_data_o,
  output decode_pkg::xlen_t       imm_o,
  output decode_pkg::alu_op_t     alu_op_o,
  output decode_pkg::mem_op_t     mem_op_o,
  output decode_pkg::inst_class_t exc_op_o,
  output logic                    illegal_o,
  output logic                    load_use_o
);

  decode_pkg::imm_fmt_t fmt;
  decode_pkg::reg_idx_t rs1;
  decode_pkg::reg_idx_t rs2;
  decode_pkg::reg_idx_t rd;
  logic                 need_rs1;
  logic                 need_rs2;
  logic                 need_rd;

  // class vector doubles as the execute op
  opcode_classifier u_classifier (
    .inst_i     (inst_i),
    .class_o    (exc_op_o),
    .fmt_o      (fmt),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rd_o       (rd),
    .need_rs1_o (need_rs1),
    .need_rs2_o (need_rs2),
    .need_rd_o  (need_rd),
    .illegal_o  (illegal_o)
  );

  imm_gen u_imm_gen (
    .inst_i (inst_i),
    .fmt_i  (fmt),
    .imm_o  (imm_o)
  );

  op_encoder u_op_encoder (
    .inst_i   (inst_i),
    .class_i  (exc_op_o),
    .alu_op_o (alu_op_o),
    .mem_op_o (mem_op_o)
  );

  operand_forward u_forward (
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .rd_i           (rd),
    .need_rs1_i     (need_rs1),
    .need_rs2_i     (need_rs2),
    .need_rd_i      (need_rd),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .ex_rd_addr_i   (ex_rd_addr_i),
    .ex_rd_data_i   (ex_rd_data_i),
    .mem_rd_addr_i  (mem_rd_addr_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .prev_is_load_i (prev_is_load_i),
    .rs1_idx_o      (rs1_idx_o),
    .rs2_idx_o      (rs2_idx_o),
    .rd_idx_o       (rd_idx_o),
    .rs1_data_o     (rs1_data_o),
    .rs2_data_o     (rs2_data_o),
    .load_use_o     (load_use_o)
  );

endmodule

//--- verification/tb_inst_decode.sv
`include "decode_config.svh"

module tb_inst_decode;

  localparam int MAX_CYCLES = 1000;

  typedef struct packed {
    decode_pkg::reg_idx_t    rs1_idx;
    decode_pkg::reg_idx_t    rs2_idx;
    decode_pkg::reg_idx_t    rd_idx;
    decode_pkg::xlen_t       rs1_data;
    decode_pkg::xlen_t       rs2_data;
    decode_pkg::xlen_t       imm;
    decode_pkg::alu_op_t     alu;
    decode_pkg::mem_op_t     mem;
    decode_pkg::inst_class_t cls;
    logic                    illegal;
    logic                    load_use;
  } expect_t;

  logic clk;
  logic rst_i;

  decode_pkg::inst_t       inst_i;
  decode_pkg::xlen_t       rs1_data_i;
  decode_pkg::xlen_t       rs2_data_i;
  decode_pkg::reg_idx_t    ex_rd_addr_i;
  decode_pkg::xlen_t       ex_rd_data_i;
  decode_pkg::reg_idx_t    mem_rd_addr_i;
  decode_pkg::xlen_t       mem_rd_data_i;
  logic                    prev_is_load_i;
  decode_pkg::reg_idx_t    rs1_idx_o;
  decode_pkg::reg_idx_t    rs2_idx_o;
  decode_pkg::reg_idx_t    rd_idx_o;
  decode_pkg::xlen_t       rs1_data_o;
  decode_pkg::xlen_t       rs2_data_o;
  decode_pkg::xlen_t       imm_o;
  decode_pkg::alu_op_t     alu_op_o;
  decode_pkg::mem_op_t     mem_op_o;
  decode_pkg::inst_class_t exc_op_o;
  logic                    illegal_o;
  logic                    load_use_o;

  integer  seed = 32'h34a5;
  int      errors = 0;
  int      errors_mark = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  int      cycles = 0;
  expect_t exp;

  inst_decode UUT (
    .inst_i         (inst_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .ex_rd_addr_i   (ex_rd_addr_i),
    .ex_rd_data_i   (ex_rd_data_i),
    .mem_rd_addr_i  (mem_rd_addr_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .prev_is_load_i (prev_is_load_i),
    .rs1_idx_o      (rs1_idx_o),
    .rs2_idx_o      (rs2_idx_o),
    .rd_idx_o       (rd_idx_o),
    .rs1_data_o     (rs1_data_o),
    .rs2_data_o     (rs2_data_o),
    .imm_o          (imm_o),
    .alu_op_o       (alu_op_o),
    .mem_op_o       (mem_op_o),
    .exc_op_o       (exc_op_o),
    .illegal_o      (illegal_o),
    .load_use_o     (load_use_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected decode straight from the RV64IM encoding rules
  function automatic expect_t decode_ref(input decode_pkg::inst_t inst,
                                         input decode_pkg::xlen_t r1d,
                                         input decode_pkg::xlen_t r2d,
                                         input decode_pkg::reg_idx_t exa,
                                         input decode_pkg::xlen_t exd,
                                         input decode_pkg::reg_idx_t mema,
                                         input decode_pkg::xlen_t memd,
                                         input logic ld);
    expect_t    e;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       use1;
    logic       use2;
    logic       use_rd;
    logic       s;
    logic       hit1;
    logic       hit2;
    e = '0;
    f7 = inst[31:25];
    f3 = inst[14:12];
    s = inst[31];
    use1 = 1'b0;
    use2 = 1'b0;
    use_rd = 1'b0;
    case (inst[6:0])
      `DEC_OPC_LOAD: begin
        e.cls.load = 1'b1;
        {use1, use_rd} = 2'b11;
        e.imm = {{52{s}}, inst[31:20]};
        e.alu.add = 1'b1;
        case (f3)
          3'd0: e.mem.lb = 1'b1;
          3'd1: e.mem.lh = 1'b1;
          3'd2: e.mem.lw = 1'b1;
          3'd3: e.mem.ld = 1'b1;
          3'd4: e.mem.lbu = 1'b1;
          3'd5: e.mem.lhu = 1'b1;
          3'd6: e.mem.lwu = 1'b1;
          default: ;
        endcase
      end
      `DEC_OPC_STORE: begin
        e.cls.store = 1'b1;
        {use1, use2} = 2'b11;
        e.imm = {{52{s}}, inst[31:25], inst[11:7]};
        e.alu.add = 1'b1;
        case (f3)
          3'd0: e.mem.sb = 1'b1;
          3'd1: e.mem.sh = 1'b1;
          3'd2: e.mem.sw = 1'b1;
          3'd3: e.mem.sd = 1'b1;
          default: ;
        endcase
      end
      `DEC_OPC_BRANCH: begin
        e.cls.branch = 1'b1;
        {use1, use2} = 2'b11;
        e.imm = {{51{s}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        case (f3)
          3'd0: e.alu.beq = 1'b1;
          3'd1: e.alu.bne = 1'b1;
          3'd4: e.alu.blt = 1'b1;
          3'd5: e.alu.bge = 1'b1;
          3'd6: e.alu.bltu = 1'b1;
          3'd7: e.alu.bgeu = 1'b1;
          default: ;
        endcase
      end
      `DEC_OPC_JALR: begin
        e.cls.jalr = 1'b1;
        {use1, use_rd} = 2'b11;
        e.imm = {{52{s}}, inst[31:20]};
        e.alu.add = 1'b1;
      end
      `DEC_OPC_JAL: begin
        e.cls.jal = 1'b1;
        use_rd = 1'b1;
        e.imm = {{43{s}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        e.alu.add = 1'b1;
      end
      `DEC_OPC_AUIPC, `DEC_OPC_LUI: begin
        e.cls.auipc = (inst[6:0] == `DEC_OPC_AUIPC);
        e.cls.lui = (inst[6:0] == `DEC_OPC_LUI);
        use_rd = 1'b1;
        e.imm = {{32{s}}, inst[31:12], 12'b0};
        e.alu.add = 1'b1;
      end
      `DEC_OPC_OP_IMM: begin
        e.cls.op_imm = 1'b1;
        {use1, use_rd} = 2'b11;
        e.imm = {{52{s}}, inst[31:20]};
        case (f3)
          3'd0: e.alu.add = 1'b1;
          3'd1: e.alu.sll = (f7[6:1] == 6'b000000);
          3'd2: e.alu.slt = 1'b1;
          3'd3: e.alu.sltu = 1'b1;
          3'd4: e.alu.xor_ = 1'b1;
          3'd5: begin
            e.alu.srl = (f7[6:1] == 6'b000000);
            e.alu.sra = (f7[6:1] == 6'b010000);
          end
          3'd6: e.alu.or_ = 1'b1;
          default: e.alu.and_ = 1'b1;
        endcase
      end
      `DEC_OPC_OP_IMM_32: begin
        e.cls.op_imm_32 = 1'b1;
        {use1, use_rd} = 2'b11;
        e.imm = {{52{s}}, inst[31:20]};
        e.alu.add = (f3 == 3'd0);
        e.alu.sllw = (f3 == 3'd1) && (f7 == 7'b0000000);
        e.alu.srlw = (f3 == 3'd5) && (f7 == 7'b0000000);
        e.alu.sraw = (f3 == 3'd5) && (f7 == 7'b0100000);
      end
      `DEC_OPC_OP: begin
        e.cls.op = 1'b1;
        {use1, use2, use_rd} = 3'b111;
        if (f7 == 7'b0000000) begin
          e.alu.add = (f3 == 3'd0);
          e.alu.sll = (f3 == 3'd1);
          e.alu.slt = (f3 == 3'd2);
          e.alu.sltu = (f3 == 3'd3);
          e.alu.xor_ = (f3 == 3'd4);
          e.alu.srl = (f3 == 3'd5);
          e.alu.or_ = (f3 == 3'd6);
          e.alu.and_ = (f3 == 3'd7);
        end else if (f7 == 7'b0100000) begin
          e.alu.sub = (f3 == 3'd0);
          e.alu.sra = (f3 == 3'd5);
        end else if (f7 == 7'b0000001) begin
          {e.alu.mul, e.alu.mulh, e.alu.mulhsu, e.alu.mulhu} = 4'b1000 >> f3;
          {e.alu.div, e.alu.divu, e.alu.rem, e.alu.remu} =
              f3[2] ? (4'b1000 >> f3[1:0]) : 4'b0000;
        end
      end
      `DEC_OPC_OP_32: begin
        e.cls.op_32 = 1'b1;
        {use1, use2, use_rd} = 3'b111;
        if (f7 == 7'b0000000) begin
          e.alu.add = (f3 == 3'd0);
          e.alu.sllw = (f3 == 3'd1);
          e.alu.srlw = (f3 == 3'd5);
        end else if (f7 == 7'b0100000) begin
          e.alu.sub = (f3 == 3'd0);
          e.alu.sraw = (f3 == 3'd5);
        end else if (f7 == 7'b0000001) begin
          e.alu.mulw = (f3 == 3'd0);
          e.alu.divw = (f3 == 3'd4);
          e.alu.divuw = (f3 == 3'd5);
          e.alu.remw = (f3 == 3'd6);
          e.alu.remuw = (f3 == 3'd7);
        end
      end
      default: e.illegal = 1'b1;
    endcase
    e.rs1_idx = use1 ? inst[19:15] : 5'd0;
    e.rs2_idx = use2 ? inst[24:20] : 5'd0;
    e.rd_idx = use_rd ? inst[11:7] : 5'd0;
    // ex beats mem beats register file and x0 is never bypassed
    hit1 = (e.rs1_idx != 5'd0) && (e.rs1_idx == exa);
    hit2 = (e.rs2_idx != 5'd0) && (e.rs2_idx == exa);
    e.rs1_data = hit1 ? exd : ((e.rs1_idx != 5'd0) && (e.rs1_idx == mema)) ? memd : r1d;
    e.rs2_data = hit2 ? exd : ((e.rs2_idx != 5'd0) && (e.rs2_idx == mema)) ? memd : r2d;
    e.load_use = ld && (hit1 || hit2);
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  // outputs settle half a cycle after the drive edge
  always @(negedge clk) begin
    if (!rst_i) begin
      exp = decode_ref(inst_i, rs1_data_i, rs2_data_i, ex_rd_addr_i, ex_rd_data_i,
                       mem_rd_addr_i, mem_rd_data_i, prev_is_load_i);
      if (rs1_idx_o !== exp.rs1_idx) report_mismatch("rs1_idx_o", rs1_idx_o, exp.rs1_idx);
      if (rs2_idx_o !== exp.rs2_idx) report_mismatch("rs2_idx_o", rs2_idx_o, exp.rs2_idx);
      if (rd_idx_o !== exp.rd_idx) report_mismatch("rd_idx_o", rd_idx_o, exp.rd_idx);
      if (rs1_data_o !== exp.rs1_data) report_mismatch("rs1_data_o", rs1_data_o, exp.rs1_data);
      if (rs2_data_o !== exp.rs2_data) report_mismatch("rs2_data_o", rs2_data_o, exp.rs2_data);
      if (imm_o !== exp.imm) report_mismatch("imm_o", imm_o, exp.imm);
      if (alu_op_o !== exp.alu) report_mismatch("alu_op_o", alu_op_o, exp.alu);
      if (mem_op_o !== exp.mem) report_mismatch("mem_op_o", mem_op_o, exp.mem);
      if (exc_op_o !== exp.cls) report_mismatch("exc_op_o", exc_op_o, exp.cls);
      if (illegal_o !== exp.illegal) report_mismatch("illegal_o", illegal_o, exp.illegal);
      if (load_use_o !== exp.load_use) report_mismatch("load_use_o", load_use_o, exp.load_use);
    end
  end

  // roughly 580 cycles of stimulus so 1000 leaves plenty of margin
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic decode_pkg::xlen_t rand64();
    rand64 = {$random(seed), $random(seed)};
  endfunction

  function automatic decode_pkg::reg_idx_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
  endfunction

  function automatic logic [6:0] func7_at(input int k);
    case (k)
      0: return 7'b0000000;
      1: return 7'b0100000;
      2: return 7'b0000001;
      3: return 7'b0000101;
      // srai with shamt[5] set
      4: return 7'b0100001;
      default: return 7'b0010000;
    endcase
  endfunction

  function automatic logic [6:0] opcode_at(input int k);
    case (k)
      0: return `DEC_OPC_LOAD;
      1: return `DEC_OPC_STORE;
      2: return `DEC_OPC_BRANCH;
      3: return `DEC_OPC_JALR;
      4: return `DEC_OPC_JAL;
      5: return `DEC_OPC_OP_IMM;
      6: return `DEC_OPC_OP;
      7: return `DEC_OPC_LUI;
      default: return `DEC_OPC_AUIPC;
    endcase
  endfunction

  // register fields limited to x0..x3 so that bypass addresses collide often
  function automatic decode_pkg::inst_t narrow_word(input logic [6:0] opc);
    logic [31:0] r;
    r = $random(seed);
    return {r[31:25], 3'b000, r[21:20], 3'b000, r[16:15], r[14:12], r[11:7], opc};
  endfunction

  task automatic drive(input decode_pkg::inst_t inst, input decode_pkg::reg_idx_t exa,
                       input decode_pkg::reg_idx_t mema, input logic ld);
    @(posedge clk);
    inst_i <= inst;
    rs1_data_i <= rand64();
    rs2_data_i <= rand64();
    ex_rd_addr_i <= exa;
    ex_rd_data_i <= rand64();
    mem_rd_addr_i <= mema;
    mem_rd_data_i <= rand64();
    prev_is_load_i <= ld;
  endtask

  task automatic apply_inst(input decode_pkg::inst_t inst);
    logic [31:0] r;
    r = $random(seed);
    drive(inst, rand_reg(), rand_reg(), r[0]);
  endtask

  task automatic close_test(input string name);
    int n;
    // last vector was compared on the previous falling edge
    @(posedge clk);
    n = errors - errors_mark;
    errors_mark = errors;
    if (n == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, n);
    end
  endtask

  initial begin
    int          k;
    int          i;
    logic [3:0]  f;
    logic [31:0] r;
    rst_i = 1'b1;
    inst_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    prev_is_load_i = 1'b0;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    for (k = 0; k < 6; k++) begin
      for (f = 0; f < 8; f++) begin
        if (k < 4) begin
          apply_inst({func7_at(k), rand_reg(), rand_reg(), f[2:0], rand_reg(), `DEC_OPC_OP});
          apply_inst({func7_at(k), rand_reg(), rand_reg(), f[2:0], rand_reg(), `DEC_OPC_OP_32});
        end
        apply_inst({func7_at(k), rand_reg(), rand_reg(), f[2:0], rand_reg(), `DEC_OPC_OP_IMM});
        apply_inst({func7_at(k), rand_reg(), rand_reg(), f[2:0], rand_reg(),
                    `DEC_OPC_OP_IMM_32});
      end
    end
    close_test("alu_ops");

    for (i = 0; i < 15; i++) begin
      for (k = 0; k < 9; k++) begin
        r = $random(seed);
        apply_inst({r[31:7], opcode_at(k)});
      end
    end
    close_test("immediates");

    for (f = 0; f < 8; f++) begin
      apply_inst($random(seed) & 32'hffff8f80 | {f[2:0], 12'h0} | `DEC_OPC_LOAD);
      apply_inst($random(seed) & 32'hffff8f80 | {f[2:0], 12'h0} | `DEC_OPC_STORE);
    end
    close_test("load_store");

    // add x7, x5, x6 against each bypass combination
    drive({7'b0, 5'd6, 5'd5, 3'b000, 5'd7, `DEC_OPC_OP}, 5'd5, 5'd5, 1'b0);
    drive({7'b0, 5'd6, 5'd5, 3'b000, 5'd7, `DEC_OPC_OP}, 5'd6, 5'd5, 1'b0);
    drive({7'b0, 5'd6, 5'd5, 3'b000, 5'd7, `DEC_OPC_OP}, 5'd9, 5'd9, 1'b0);
    drive({7'b0, 5'd0, 5'd0, 3'b000, 5'd7, `DEC_OPC_OP}, 5'd0, 5'd0, 1'b0);
    drive({20'h0_3_0_1_8, 5'd1, `DEC_OPC_LUI}, 5'd3, 5'd3, 1'b0);
    drive({20'h0_4_0_5_0, 5'd2, `DEC_OPC_JAL}, 5'd10, 5'd4, 1'b0);
    for (i = 0; i < 40; i++) begin
      r = $random(seed);
      drive(narrow_word(opcode_at(r[3:0] % 9)), {3'b0, r[5:4]}, {3'b0, r[7:6]}, 1'b0);
    end
    close_test("forwarding");

    // store uses rs2 while lui uses no source
    drive({7'b0, 5'd4, 5'd1, 3'b011, 5'd0, `DEC_OPC_STORE}, 5'd4, 5'd0, 1'b1);
    drive({20'h0_4_0_2_0, 5'd4, `DEC_OPC_LUI}, 5'd4, 5'd0, 1'b1);
    drive({12'h0, 5'd0, 3'b000, 5'd3, `DEC_OPC_OP_IMM}, 5'd0, 5'd0, 1'b1);
    for (i = 0; i < 60; i++) begin
      r = $random(seed);
      drive(narrow_word(opcode_at(r[3:0] % 9)), {3'b0, r[5:4]}, {3'b0, r[7:6]}, r[8]);
    end
    close_test("load_use");

    // ecall, fence, fence.i and mret are all outside the supported classes
    apply_inst(32'h00000073);
    apply_inst(32'h0000000f);
    apply_inst(32'h0000100f);
    apply_inst(32'h30200073);
    for (i = 0; i < 150; i++) begin
      apply_inst($random(seed));
    end
    close_test("random_words");

    $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/decode_pkg.sv
source/opcode_classifier.sv
source/imm_gen.sv
source/op_encoder.sv
source/operand_forward.sv
source/inst_decode.sv
verification/tb_inst_decode.sv
